// File: tb.f
source/oserdes_pkg.sv
source/slot_word_if.sv
source/tx_word_fifo.sv
source/slot_mapper.sv
source/oserdes_shifter.sv
source/tx_lane_top.sv
verif/tx_lane_properties.sv
verif/tx_lane_tb.sv

// File: Bender.yml
package:
  name: tx_lane

sources:
  # Lane RTL in compile order
  - files:
      - source/oserdes_pkg.sv
      - source/slot_word_if.sv
      - source/tx_word_fifo.sv
      - source/slot_mapper.sv
      - source/oserdes_shifter.sv
      - source/tx_lane_top.sv

  # Testbench and bound assertions
  - target: test
    files:
      - verif/tx_lane_properties.sv
      - verif/tx_lane_tb.sv

// File: verif/tx_lane_tb.sv
`timescale 1ns/1ps

module tx_lane_tb
   import oserdes_pkg::*;
();

   localparam int CLK_PERIOD  = 100;        // ns
   localparam int RESET_CYC   = 16;
   localparam int SEED        = 10914;
   localparam int FIFO_DEPTH  = 4;
   localparam int TRI_WIDTH   = 4;
   localparam int N_MODE_WORDS = 3;         // Single words per mode
   localparam int N_TRI_WORDS = 8;
   localparam int N_BURSTS    = 3;
   localparam int BURST_LEN   = 10;
   localparam int N_OVF_PUSH  = 9;          // Back-to-back pushes that overrun the queue
   localparam int N_UNR       = 2;
   localparam int TOTAL_WORDS = 4 * N_MODE_WORDS + N_TRI_WORDS + N_BURSTS * BURST_LEN
                                + N_OVF_PUSH + N_UNR;
   // Slot time per word plus push, drain and reset overhead
   localparam int WATCHDOG_NS = (TOTAL_WORDS * SLOT_MAX + TOTAL_WORDS * 12 + 100) * CLK_PERIOD;

   logic       clk;
   logic       arst_n;
   logic       push;
   logic [7:0] push_data;
   logic [3:0] push_tri;
   ser_mode_e  push_mode;
   logic       full;
   logic       overflow;
   logic       oq;
   logic       tq;
   logic       underrun;

   int errors   = 0;
   int pass_cnt = 0;
   int fail_cnt = 0;
   int cyc_cnt  = 0;                        // Counted at falling edges
   int ovf_cnt  = 0;                        // Overflow pulses seen on the DUT
   int unr_cnt  = 0;                        // Underrun pulses seen on the DUT
   int unr_cyc  = 0;                        // Cycle of the latest underrun
   int drop_cnt = 0;                        // Pushes the model dropped

   tx_lane_top #(
      .FIFO_DEPTH (FIFO_DEPTH),
      .TRI_WIDTH  (TRI_WIDTH)
   ) u_dut (
      .clk       (clk),
      .arst_n    (arst_n),
      .push      (push),
      .push_data (push_data),
      .push_tri  (push_tri),
      .push_mode (push_mode),
      .full      (full),
      .overflow  (overflow),
      .oq        (oq),
      .tq        (tq),
      .underrun  (underrun)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   ////////////////////////////////////////////////////////////
   // Reference model helpers
   ////////////////////////////////////////////////////////////

   function automatic int mode_len(input int mode);
      if (mode == 0 || mode == 2) begin
         mode_len = 8;                      // 8:1 and SDR 4:1
      end else begin
         mode_len = 4;                      // 4:1 and SDR 2:1
      end
   endfunction

   // Expected data and tristate per slot position
   task automatic expand_word(input word_t w, output logic [7:0] d, output logic [7:0] t,
                              output int len);
      logic doubled;
      len     = mode_len(int'(w.mode));
      doubled = (w.mode == MODE_SDR_4TO1) || (w.mode == MODE_SDR_2TO1);
      d = '0;
      t = '0;
      for (int i = 0; i < len; i++) begin
         d[i] = doubled ? w.data[i / 2] : w.data[i];
         t[i] = (TRI_WIDTH == 1) ? w.tri_bits[0] : w.tri_bits[(i * 4) / len]; // Quarters
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      assert (got === exp) else begin
         errors++;
         $display("mismatch at %0t ns: %s is %b, expected %b", $time, name, got, exp);
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Cycle model and output compare
   ////////////////////////////////////////////////////////////

   word_t      mq[$];                       // Words held in the queue
   logic [1:0] line_q[$];                   // Remaining {data, tri} slots of the word
   logic       active  = 1'b0;              // A word slot is on the line
   logic       exp_oq  = IDLE_OQ;
   logic       exp_tq  = IDLE_TQ;
   logic       exp_full = 1'b0;
   logic       exp_ovf = 1'b0;
   logic       exp_unr = 1'b0;

   always @(negedge clk) begin
      logic [7:0] d;
      logic [7:0] t;
      int         len;
      int         depth_now;
      word_t      w;
      cyc_cnt++;
      if (overflow) ovf_cnt++;
      if (underrun) begin
         unr_cnt++;
         unr_cyc = cyc_cnt;
      end
      check_bit("oq", oq, exp_oq);          // Outputs after the edge just passed
      check_bit("tq", tq, exp_tq);
      check_bit("full", full, exp_full);
      check_bit("overflow", overflow, exp_ovf);
      check_bit("underrun", underrun, exp_unr);
      if (!arst_n) begin
         mq.delete();
         line_q.delete();
         active   = 1'b0;
         exp_oq   = IDLE_OQ;
         exp_tq   = IDLE_TQ;
         exp_full = 1'b0;
         exp_ovf  = 1'b0;
         exp_unr  = 1'b0;
      end else begin
         exp_ovf   = 1'b0;
         exp_unr   = 1'b0;
         depth_now = mq.size();             // Queue level before the coming edge
         if (!active || line_q.size() == 0) begin
            if (depth_now != 0) begin
               w = mq.pop_front();          // Word boundary loads the next word
               expand_word(w, d, t, len);
               exp_oq = d[0];
               exp_tq = t[0];
               active = 1'b1;
               line_q.delete();
               for (int i = 1; i < len; i++) line_q.push_back({d[i], t[i]});
            end else begin
               if (active) exp_unr = 1'b1;  // Queue dry after the last slot
               active = 1'b0;
               exp_oq = IDLE_OQ;
               exp_tq = IDLE_TQ;
            end
         end else begin
            {exp_oq, exp_tq} = line_q.pop_front();
         end
         if (push) begin
            if (depth_now == FIFO_DEPTH) begin
               exp_ovf = 1'b1;              // Dropped word
               drop_cnt++;
            end else begin
               w.data     = push_data;
               w.tri_bits = push_tri;
               w.mode     = push_mode;
               mq.push_back(w);
            end
         end
         exp_full = (mq.size() == FIFO_DEPTH);
      end
   end

   ////////////////////////////////////////////////////////////
   // Stimulus tasks
   ////////////////////////////////////////////////////////////

   // Pushes n words every other cycle while not full and waits for the drain
   task automatic run_burst(input int n, input int mode_sel, input logic rand_tri);
      int start_cyc;
      int sum_len;
      int base_unr;
      int m;
      int waited;
      base_unr  = unr_cnt;
      sum_len   = 0;
      start_cyc = 0;
      for (int k = 0; k < n; k++) begin
         m = (mode_sel < 0) ? int'($urandom_range(3, 0)) : mode_sel;
         @(negedge clk);
         while (full) @(negedge clk);
         @(posedge clk);
         if (k == 0) start_cyc = cyc_cnt;
         push      <= 1'b1;
         push_data <= 8'($urandom);
         push_tri  <= rand_tri ? 4'($urandom) : 4'b0000;
         push_mode <= ser_mode_e'(m);
         @(posedge clk);
         push      <= 1'b0;
         sum_len += mode_len(m);
      end
      waited = 0;
      while (unr_cnt == base_unr && waited < sum_len + 20) begin
         @(posedge clk);
         waited++;
      end
      assert (unr_cnt == base_unr + 1) else begin
         errors++;
         $display("lane did not signal underrun once after the words drained");
      end
      // Write and load before the first slot and no gap between words
      assert (unr_cyc == start_cyc + 3 + sum_len) else begin
         errors++;
         $display("mismatch at %0t ns: underrun at cycle %0d, expected %0d", $time,
                  unr_cyc, start_cyc + 3 + sum_len);
      end
      repeat (3) @(negedge clk);
      check_bit("idle oq", oq, IDLE_OQ);
      check_bit("idle tq", tq, IDLE_TQ);
      assert (unr_cnt == base_unr + 1) else begin
         errors++;
         $display("extra underrun pulse while the lane was idle");
      end
   endtask

   task automatic test_overflow();
      int base_drop;
      int base_ovf;
      int base_unr;
      int waited;
      base_drop = drop_cnt;
      base_ovf  = ovf_cnt;
      base_unr  = unr_cnt;
      for (int k = 0; k < N_OVF_PUSH; k++) begin
         @(posedge clk);
         push      <= 1'b1;                 // Pushed every cycle past the queue depth
         push_data <= 8'($urandom);
         push_tri  <= 4'($urandom);
         push_mode <= MODE_8TO1;
      end
      @(posedge clk);
      push <= 1'b0;
      waited = 0;
      while (unr_cnt == base_unr && waited < N_OVF_PUSH * SLOT_MAX + 20) begin
         @(posedge clk);
         waited++;
      end
      assert (unr_cnt == base_unr + 1) else begin
         errors++;
         $display("lane did not drain after the overflow burst");
      end
      assert (ovf_cnt > base_ovf) else begin
         errors++;
         $display("no overflow pulse although the queue was pushed past its depth");
      end
      assert (ovf_cnt - base_ovf == drop_cnt - base_drop) else begin
         errors++;
         $display("mismatch at %0t ns: %0d overflow pulses, expected %0d", $time,
                  ovf_cnt - base_ovf, drop_cnt - base_drop);
      end
   endtask

   task automatic end_test(input string name, input int err_start);
      if (errors == err_start) begin
         pass_cnt++;
         $display("test %s: ok", name);
      end else begin
         fail_cnt++;
         $display("test %s: %0d errors", name, errors - err_start);
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////

   initial begin
      int err_start;
      clk       = 1'b0;
      arst_n    = 1'b0;
      push      = 1'b0;
      push_data = '0;
      push_tri  = '0;
      push_mode = MODE_8TO1;
      void'($urandom(SEED));

      err_start = errors;
      repeat (RESET_CYC) begin
         @(negedge clk);
         check_bit("oq in reset", oq, IDLE_OQ);
         check_bit("tq in reset", tq, IDLE_TQ);
      end
      @(posedge clk);
      arst_n <= 1'b1;
      repeat (2) begin
         @(negedge clk);
         check_bit("oq after reset", oq, 1'b0);
         check_bit("tq after reset", tq, 1'b1);
         check_bit("full after reset", full, 1'b0);
         check_bit("overflow after reset", overflow, 1'b0);
         check_bit("underrun after reset", underrun, 1'b0);
      end
      end_test("reset", err_start);

      err_start = errors;
      for (int m = 0; m < 4; m++) begin
         repeat (N_MODE_WORDS) run_burst(1, m, 1'b0);
      end
      end_test("mode mapping", err_start);

      err_start = errors;
      repeat (N_TRI_WORDS) run_burst(1, -1, 1'b1);
      end_test("tristate slicing", err_start);

      err_start = errors;
      repeat (N_BURSTS) run_burst(BURST_LEN, -1, 1'b1);
      end_test("gapless streaming", err_start);

      err_start = errors;
      test_overflow();
      end_test("overflow", err_start);

      err_start = errors;
      repeat (N_UNR) run_burst(1, -1, 1'b1);
      end_test("underrun", err_start);

      $display("summary: %0d tests passed, %0d tests failed, %0d errors",
               pass_cnt, fail_cnt, errors);
      if (errors == 0 && fail_cnt == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog timeout, run did not finish within %0d ns", WATCHDOG_NS);
      $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

// File: verif/tx_lane_properties.sv
`timescale 1ns/1ps

module tx_lane_properties
   import oserdes_pkg::*;
(
   input logic clk,
   input logic arst_n,
   input logic pop,                         // Shifter takes the head word
   input logic underrun,
   input logic tq,
   input logic in_idle                      // Shifter FSM in SH_IDLE
);

   ////////////////////////////////////////////////////////////
   // Shifter rules
   ////////////////////////////////////////////////////////////

   // A popped word is on the line from the next cycle on
   property p_pop_loads_word;
      @(posedge clk) disable iff (!arst_n)
         pop |=> !in_idle;
   endproperty

   property p_underrun_one_cycle;
      @(posedge clk) disable iff (!arst_n)
         underrun |=> !underrun;
   endproperty

   // Line stays tristated while nothing is sent
   property p_idle_tq;
      @(posedge clk) disable iff (!arst_n)
         in_idle |-> (tq == IDLE_TQ);
   endproperty

   a_pop_loads_word: assert property (p_pop_loads_word)
      else $error("popped word did not move the shifter into SH_SEND");

   a_underrun_one_cycle: assert property (p_underrun_one_cycle)
      else $error("underrun held for more than one cycle");

   a_idle_tq: assert property (p_idle_tq)
      else $error("tq not at idle level in SH_IDLE");

endmodule

bind oserdes_shifter tx_lane_properties u_props (
   .clk      (clk),
   .arst_n   (arst_n),
   .pop      (s.pop),
   .underrun (underrun),
   .tq       (tq),
   .in_idle  (state == SH_IDLE)
);

// File: source/tx_lane_top.sv
`timescale 1ns/1ps

module tx_lane_top
   import oserdes_pkg::*;
#(
   parameter int FIFO_DEPTH = 4,            // Words held ahead of the shifter
   parameter int TRI_WIDTH  = 1             // 1 or 4 tristate bits per word
) (
   input  logic       clk,
   input  logic       arst_n,
   input  logic       push,                 // Fabric write strobe
   input  logic [7:0] push_data,
   input  logic [3:0] push_tri,
   input  ser_mode_e  push_mode,
   output logic       full,
   output logic       overflow,
   output logic       oq,                   // Serial data out
   output logic       tq,                   // Tristate control out
   output logic       underrun
);

   word_t push_word;                        // Packed push fields
   word_t head_word;                        // Queue head into the mapper

   assign push_word = '{data: push_data, tri_bits: push_tri, mode: push_mode};

   slot_word_if u_sw ();                    // Queue, mapper and shifter link

   ////////////////////////////////////////////////////////////
   // Lane datapath
   ////////////////////////////////////////////////////////////

   tx_word_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_fifo (
      .clk       (clk),
      .arst_n    (arst_n),
      .push      (push),
      .push_word (push_word),
      .full      (full),
      .overflow  (overflow),
      .head      (head_word),
      .q         (u_sw.queue)
   );

   slot_mapper #(
      .TRI_WIDTH (TRI_WIDTH)
   ) u_mapper (
      .head (head_word),
      .m    (u_sw.mapper)
   );

   oserdes_shifter u_shifter (
      .clk      (clk),
      .arst_n   (arst_n),
      .s        (u_sw.shifter),
      .oq       (oq),
      .tq       (tq),
      .underrun (underrun)
   );

endmodule

// File: source/oserdes_shifter.sv
`timescale 1ns/1ps

module oserdes_shifter
   import oserdes_pkg::*;
(
   input  logic          clk,
   input  logic          arst_n,
   slot_word_if.shifter  s,
   output logic          oq,                // Serial data, registered
   output logic          tq,                // Tristate control, registered
   output logic          underrun           // Queue empty at word boundary
);

   typedef enum logic {
      SH_IDLE,                              // Nothing on the line
      SH_SEND                               // A word is being shifted out
   } sh_state_e;

   sh_state_e           state;
   logic [LEN_W-1:0]    cnt;                // Slots left after the one shown
   logic [SLOT_MAX-1:0] sh_d;               // Data slots still to send
   logic [SLOT_MAX-1:0] sh_t;               // Tristate slots still to send
   logic                last_slot;
   logic                load;

   ////////////////////////////////////////////////////////////
   // Word boundary
   ////////////////////////////////////////////////////////////

   assign last_slot = (state == SH_SEND) && (cnt == '0);  // Final slot on the line
   assign load      = ((state == SH_IDLE) || last_slot) && s.valid;
   assign s.pop     = load;                 // Take head word as it is loaded

   ////////////////////////////////////////////////////////////
   // Control and output registers
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state    <= SH_IDLE;
         cnt      <= '0;
         oq       <= IDLE_OQ;
         tq       <= IDLE_TQ;
         underrun <= 1'b0;
      end else begin
         underrun <= 1'b0;                  // Single-cycle pulse
         if (load) begin
            state <= SH_SEND;
            cnt   <= s.len - LEN_W'(1);     // Slot 0 goes out now
            oq    <= s.slots[0];
            tq    <= s.tslots[0];
         end else if (last_slot) begin
            // Queue ran dry, fall back to the idle line levels
            state    <= SH_IDLE;
            oq       <= IDLE_OQ;
            tq       <= IDLE_TQ;
            underrun <= 1'b1;
         end else if (state == SH_SEND) begin
            cnt <= cnt - LEN_W'(1);
            oq  <= sh_d[0];                 // Next slot of the current word
            tq  <= sh_t[0];
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // Slot shift registers
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (load) begin
         sh_d <= s.slots >> 1;              // Slot 0 already on oq
         sh_t <= s.tslots >> 1;
      end else if (state == SH_SEND) begin
         sh_d <= sh_d >> 1;                 // LSB first
         sh_t <= sh_t >> 1;
      end
   end

endmodule

// File: source/slot_mapper.sv
`timescale 1ns/1ps

module slot_mapper
   import oserdes_pkg::*;
#(
   parameter int TRI_WIDTH = 1              // 1 or 4 tristate bits used
) (
   input  word_t        head,               // Head word of the queue
   slot_word_if.mapper  m
);

   logic [LEN_W-1:0] word_len;

   assign word_len = slot_len(head.mode);
   assign m.len    = word_len;

   ////////////////////////////////////////////////////////////
   // Data slots
   ////////////////////////////////////////////////////////////

   always_comb begin
      m.slots = '0;                         // Unused positions stay zero
      case (head.mode)
         MODE_8TO1: begin
            m.slots = head.data;            // D0..D7
         end
         MODE_4TO1: begin
            m.slots[3:0] = head.data[3:0];  // D0..D3
         end
         MODE_SDR_4TO1: begin
            for (int i = 0; i < 4; i++) begin
               m.slots[2*i]   = head.data[i]; // Each bit held two slots
               m.slots[2*i+1] = head.data[i];
            end
         end
         default: begin                     // SDR 2:1
            for (int i = 0; i < 2; i++) begin
               m.slots[2*i]   = head.data[i];
               m.slots[2*i+1] = head.data[i];
            end
         end
      endcase
   end

   ////////////////////////////////////////////////////////////
   // Tristate slots
   ////////////////////////////////////////////////////////////

   always_comb begin
      logic [1:0] qidx;                     // Quarter of the word a slot falls in
      m.tslots = '0;
      for (int k = 0; k < SLOT_MAX; k++) begin
         qidx = (word_len == LEN_W'(8)) ? 2'(k >> 1) : 2'(k); // 2 or 1 slots per quarter
         if (k < int'(word_len)) begin
            if (TRI_WIDTH == 1) begin
               m.tslots[k] = head.tri_bits[0];    // Whole word follows T0
            end else begin
               m.tslots[k] = head.tri_bits[qidx]; // T0..T3 in order
            end
         end
      end
   end

endmodule

// File: source/tx_word_fifo.sv
`timescale 1ns/1ps

module tx_word_fifo
   import oserdes_pkg::*;
#(
   parameter int FIFO_DEPTH = 4
) (
   input  logic        clk,
   input  logic        arst_n,
   input  logic        push,                // Write strobe from fabric
   input  word_t       push_word,
   output logic        full,
   output logic        overflow,            // One-cycle pulse per dropped push
   output word_t       head,                // Oldest word, seen combinationally
   slot_word_if.queue  q
);

   localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

   ////////////////////////////////////////////////////////////
   // Storage and pointers
   ////////////////////////////////////////////////////////////

   word_t            mem [FIFO_DEPTH];      // Word storage
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;                 // Occupancy
   logic             wr_en;
   logic             rd_en;

   assign full    = (count == CNT_W'(FIFO_DEPTH));
   assign q.valid = (count != '0);          // Not empty
   assign wr_en   = push && !full;          // Push while full is dropped
   assign rd_en   = q.pop && q.valid;       // Pop only takes a real word
   assign head    = mem[rd_ptr];

   // Pointer step with wrap at the last entry
   function automatic logic [PTR_W-1:0] ptr_next(logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
         ptr_next = '0;
      end else begin
         ptr_next = ptr + PTR_W'(1);
      end
   endfunction

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= push_word;          // One-cycle write
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         count    <= '0;
         overflow <= 1'b0;
      end else begin
         overflow <= push && full;          // Flag the drop on the next edge
         if (wr_en) begin
            wr_ptr <= ptr_next(wr_ptr);
         end
         if (rd_en) begin
            rd_ptr <= ptr_next(rd_ptr);
         end
         case ({wr_en, rd_en})
            2'b10:   count <= count + CNT_W'(1);
            2'b01:   count <= count - CNT_W'(1);
            default: count <= count;        // Both or neither, no change
         endcase
      end
   end

endmodule

// File: source/slot_word_if.sv
`timescale 1ns/1ps

interface slot_word_if
   import oserdes_pkg::*;
();

   logic                valid;              // Queue holds at least one word
   logic [SLOT_MAX-1:0] slots;              // Data slots, slot 0 sent first
   logic [SLOT_MAX-1:0] tslots;             // Tristate level per slot
   logic [LEN_W-1:0]    len;                // Slots used by the head word
   logic                pop;                // Head word taken at this edge

   modport queue (
      output valid,
      input  pop
   );

   modport mapper (
      output slots,
      output tslots,
      output len
   );

   modport shifter (
      input  valid,
      input  slots,
      input  tslots,
      input  len,
      output pop
   );

endinterface

// File: source/oserdes_pkg.sv
package oserdes_pkg;

   ////////////////////////////////////////////////////////////
   // Serialization modes and slot geometry
   ////////////////////////////////////////////////////////////

   typedef enum logic [1:0] {
      MODE_8TO1     = 2'd0,                 // D0..D7, one bit per slot
      MODE_4TO1     = 2'd1,                 // D0..D3
      MODE_SDR_4TO1 = 2'd2,                 // D0,D0 .. D3,D3
      MODE_SDR_2TO1 = 2'd3                  // D0,D0,D1,D1
   } ser_mode_e;

   localparam int SLOT_MAX = 8;             // Slot positions per mapped word
   localparam int LEN_W    = 4;             // Holds a length of up to 8

   // One pushed word, 14 bits in all
   typedef struct packed {
      logic [7:0] data;                     // Parallel data bits
      logic [3:0] tri_bits;                 // Tristate bits, T0 first
      ser_mode_e  mode;                     // Per-word serialization mode
   } word_t;

   localparam logic IDLE_OQ = 1'b0;         // Data line value between words
   localparam logic IDLE_TQ = 1'b1;         // Line tristated when idle

   // Slots a word of the given mode occupies on the output
   function automatic logic [LEN_W-1:0] slot_len(ser_mode_e mode);
      case (mode)
         MODE_8TO1:     slot_len = LEN_W'(8);
         MODE_4TO1:     slot_len = LEN_W'(4);
         MODE_SDR_4TO1: slot_len = LEN_W'(8); // Four bits, each doubled
         default:       slot_len = LEN_W'(4); // SDR 2:1, two bits doubled
      endcase
   endfunction

endpackage
